/* list.f */
design/obi_integrity_pkg.sv
design/obi_outstanding_fifo.sv
design/obi_instr_channel.sv
design/obi_data_channel.sv
design/integrity_csr.sv
design/obi_integrity_top.sv
testbench/tb_obi_integrity_checks.sv
testbench/tb_obi_integrity.sv

/* Bender.yml */
package:
  name: obi_integrity

sources:
  - design/obi_integrity_pkg.sv
  - design/obi_outstanding_fifo.sv
  - design/obi_instr_channel.sv
  - design/obi_data_channel.sv
  - design/integrity_csr.sv
  - design/obi_integrity_top.sv
  - target: test
    files:
      - testbench/tb_obi_integrity_checks.sv
      - testbench/tb_obi_integrity.sv

/* testbench/tb_obi_integrity.sv */
// Testbench for the OBI bus interface integrity unit
// Plays core and bus on both OBI ports with random traffic and injected faults
`default_nettype none

module tb_obi_integrity
  import obi_integrity_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLEAN_CYCLES   = 300;
  // Reset, drain and the directed tests add fewer than 60 cycles
  localparam int TIMEOUT_CYCLES = CLEAN_CYCLES + 60 + 200;

  logic                 clk_i = 1'b0;
  logic                 rst;
  logic                 instr_req, instr_dbg, instr_gnt, instr_gntpar;
  logic                 instr_rvalid, instr_rvalidpar, instr_err;
  logic                 instr_reqpar, instr_integrity_err;
  logic                 data_req, data_dbg, data_we, data_gnt, data_gntpar;
  logic                 data_rvalid, data_rvalidpar, data_err;
  logic                 data_reqpar, data_integrity_err;
  logic [ADDR_W-1:0]    instr_addr, data_addr;
  logic [PROT_W-1:0]    instr_prot, data_prot;
  logic [MEMTYPE_W-1:0] instr_memtype, data_memtype;
  logic [BE_W-1:0]      data_be;
  logic [DATA_W-1:0]    data_wdata, instr_rdata, data_rdata;
  logic [RCHK_W-1:0]    instr_rchk, data_rchk;
  logic [ACHK_W-1:0]    instr_achk, data_achk;
  logic                 cfg_we, cfg_wdata, status_clear;
  logic                 integrity_enable, alert_major, alert_status;

  logic [31:0] rand_state = 32'd53;
  int          instr_pending = 0;
  int          data_pending = 0;
  int          test_count = 0;
  int          errors_at_start = 0;
  int          cycle_count = 0;

  obi_integrity_top u_obi_integrity_top (.*);

  tb_obi_integrity_checks u_checks (.*);

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Timeout: the run took more than %0d cycles", TIMEOUT_CYCLES);
      $display("Testbench failed");
      $finish;
    end
  end

  // xorshift32
  function automatic logic [31:0] next_rand();
    rand_state ^= rand_state << 13;
    rand_state ^= rand_state >> 17;
    rand_state ^= rand_state << 5;
    return rand_state;
  endfunction

  task automatic idle_inputs();
    {instr_req, instr_gnt, instr_rvalid, instr_err} = '0;
    {data_req, data_gnt, data_rvalid, data_err} = '0;
    // Parity strobes sit at the inverse of their low strobes
    {instr_gntpar, instr_rvalidpar, data_gntpar, data_rvalidpar} = '1;
    {instr_rdata, instr_rchk, data_rdata, data_rchk} = '0;
    {cfg_we, cfg_wdata, status_clear} = '0;
    instr_addr    = next_rand();
    instr_prot    = PROT_W'(next_rand());
    instr_memtype = MEMTYPE_W'(next_rand());
    instr_dbg     = 1'(next_rand());
    data_addr     = next_rand();
    data_prot     = PROT_W'(next_rand());
    data_memtype  = MEMTYPE_W'(next_rand());
    data_dbg      = 1'(next_rand());
    data_we       = 1'(next_rand());
    data_be       = BE_W'(next_rand());
    data_wdata    = next_rand();
  endtask

  // Granted request with gntpar low unless flipped
  task automatic request(input bit on_data, input bit we, input bit gntpar_flip);
    if (on_data) begin
      data_req    = 1'b1;
      data_gnt    = 1'b1;
      data_gntpar = gntpar_flip;
      data_we     = we;
      data_pending++;
    end else begin
      instr_req    = 1'b1;
      instr_gnt    = 1'b1;
      instr_gntpar = gntpar_flip;
      instr_pending++;
    end
  endtask

  task automatic respond(input bit on_data, input logic [RCHK_W-1:0] rchk_flip,
                         input bit rvpar_flip);
    logic [DATA_W-1:0] rdata;
    logic              err;
    rdata = next_rand();
    err   = (next_rand() % 8) == 0;
    if (on_data) begin
      data_rvalid    = 1'b1;
      data_rvalidpar = rvpar_flip;
      data_rdata     = rdata;
      data_err       = err;
      data_rchk      = u_checks.ref_rchk(rdata, err) ^ rchk_flip;
      data_pending--;
    end else begin
      instr_rvalid    = 1'b1;
      instr_rvalidpar = rvpar_flip;
      instr_rdata     = rdata;
      instr_err       = err;
      instr_rchk      = u_checks.ref_rchk(rdata, err) ^ rchk_flip;
      instr_pending--;
    end
  endtask

  // A response goes out before a new grant so the FIFO never overflows
  task automatic random_cycle();
    idle_inputs();
    if (instr_pending > 0 && next_rand() % 2 == 0) begin
      respond(1'b0, '0, 1'b0);
    end
    if (instr_pending < OUTSTANDING_DEPTH && next_rand() % 2 == 0) begin
      request(1'b0, 1'b0, 1'b0);
    end
    if (data_pending > 0 && next_rand() % 2 == 0) begin
      respond(1'b1, '0, 1'b0);
    end
    if (data_pending < OUTSTANDING_DEPTH && next_rand() % 2 == 0) begin
      request(1'b1, 1'(next_rand()), 1'b0);
    end
    @(negedge clk_i);
  endtask

  task automatic drain();
    while (instr_pending > 0 || data_pending > 0) begin
      idle_inputs();
      if (instr_pending > 0) begin
        respond(1'b0, '0, 1'b0);
      end
      if (data_pending > 0) begin
        respond(1'b1, '0, 1'b0);
      end
      @(negedge clk_i);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      idle_inputs();
      @(negedge clk_i);
    end
  endtask

  // Grant, response one cycle later, then one idle cycle for the alert
  task automatic directed_txn(input bit on_data, input bit we, input bit gntpar_flip,
                              input logic [RCHK_W-1:0] rchk_flip, input bit rvpar_flip);
    idle_inputs();
    request(on_data, we, gntpar_flip);
    @(negedge clk_i);
    idle_inputs();
    respond(on_data, rchk_flip, rvpar_flip);
    @(negedge clk_i);
    idle_cycles(1);
  endtask

  task automatic write_enable(input bit value);
    idle_inputs();
    cfg_we    = 1'b1;
    cfg_wdata = value;
    @(negedge clk_i);
  endtask

  task automatic clear_status();
    idle_inputs();
    status_clear = 1'b1;
    @(negedge clk_i);
  endtask

  task automatic start_test(input string name);
    u_checks.test_name = name;
    errors_at_start    = u_checks.error_count;
  endtask

  task automatic end_test();
    test_count++;
    $display("Test %s finished with %0d errors", u_checks.test_name,
             u_checks.error_count - errors_at_start);
  endtask

  initial begin
    idle_inputs();
    rst = 1'b1;
    repeat (3) @(negedge clk_i);
    rst = 1'b0;

    start_test("reset_state");
    idle_cycles(2);
    end_test();

    start_test("clean_traffic");
    repeat (CLEAN_CYCLES) random_cycle();
    drain();
    idle_cycles(2);
    end_test();

    start_test("rchk_fault");
    directed_txn(1'b1, 1'b0, 1'b0, 5'b00001, 1'b0);
    directed_txn(1'b1, 1'b1, 1'b0, 5'b10000, 1'b0);
    // Lower bits of a store rchk are not compared
    directed_txn(1'b1, 1'b1, 1'b0, 5'b00010, 1'b0);
    directed_txn(1'b0, 1'b0, 1'b0, 5'b01000, 1'b0);
    clear_status();
    idle_cycles(1);
    end_test();

    start_test("integrity_disabled");
    write_enable(1'b0);
    directed_txn(1'b1, 1'b0, 1'b0, 5'b00101, 1'b0);
    directed_txn(1'b0, 1'b0, 1'b0, 5'b11111, 1'b0);
    end_test();

    start_test("parity_faults");
    // gnt parity faults on both ports while checking is still off
    directed_txn(1'b1, 1'b0, 1'b1, 5'b00000, 1'b0);
    directed_txn(1'b0, 1'b0, 1'b1, 5'b00000, 1'b0);
    idle_cycles(4);
    clear_status();
    write_enable(1'b1);
    directed_txn(1'b0, 1'b0, 1'b0, 5'b00000, 1'b1);
    directed_txn(1'b1, 1'b1, 1'b0, 5'b00000, 1'b1);
    idle_cycles(2);
    clear_status();
    idle_cycles(2);
    end_test();

    $display("%0d tests, %0d checks, %0d errors", test_count, u_checks.check_count,
             u_checks.error_count);
    if (u_checks.error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/tb_obi_integrity_checks.sv */
// Checker for the OBI integrity unit
// Reference checksums, an outstanding-request model and the assertions on the DUT ports
`default_nettype none

module tb_obi_integrity_checks
  import obi_integrity_pkg::*;
(
  input wire logic                 clk_i,
  input wire logic                 rst,
  input wire logic                 instr_req, instr_dbg, instr_gnt, instr_gntpar,
  input wire logic                 instr_rvalid, instr_rvalidpar, instr_err,
  input wire logic                 instr_reqpar, instr_integrity_err,
  input wire logic                 data_req, data_dbg, data_we, data_gnt, data_gntpar,
  input wire logic                 data_rvalid, data_rvalidpar, data_err,
  input wire logic                 data_reqpar, data_integrity_err,
  input wire logic [ADDR_W-1:0]    instr_addr, data_addr,
  input wire logic [PROT_W-1:0]    instr_prot, data_prot,
  input wire logic [MEMTYPE_W-1:0] instr_memtype, data_memtype,
  input wire logic [BE_W-1:0]      data_be,
  input wire logic [DATA_W-1:0]    data_wdata, instr_rdata, data_rdata,
  input wire logic [RCHK_W-1:0]    instr_rchk, data_rchk,
  input wire logic [ACHK_W-1:0]    instr_achk, data_achk,
  input wire logic                 cfg_we, cfg_wdata, status_clear,
  input wire logic                 integrity_enable, alert_major, alert_status
);

  timeunit 1ns;
  timeprecision 1ps;

  string      test_name = "reset";
  int         error_count = 0;
  int         check_count = 0;
  // Entries are {had_integrity, gnt_fault} and {had_integrity, gnt_fault, is_store}
  logic [1:0] instr_q[$];
  logic [2:0] data_q[$];
  logic       enable_q = 1'b1;
  logic       status_q = 1'b0;
  logic       fault_q = 1'b0;

  function automatic logic [ACHK_W-1:0] ref_achk(
    input logic [31:0] addr, wdata,
    input logic [3:0]  be,
    input logic        we,
    input logic [2:0]  prot,
    input logic [1:0]  memtype,
    input logic        dbg
  );
    logic [ACHK_W-1:0] chk;
    for (int i = 0; i < 4; i++) begin
      chk[i]     = ^addr[8*i +: 8];
      chk[9 + i] = ^wdata[8*i +: 8];
    end
    chk[4] = ~^{prot, memtype};
    chk[5] = ~^{be, we};
    // mid and atop are zero so their parity bits are zero
    chk[6] = 1'b0;
    chk[7] = 1'b0;
    chk[8] = !dbg;
    return chk;
  endfunction

  function automatic logic [RCHK_W-1:0] ref_rchk(input logic [31:0] rdata, input logic err);
    logic [RCHK_W-1:0] chk;
    for (int i = 0; i < 4; i++) begin
      chk[i] = ^rdata[8*i +: 8];
    end
    // exokay is zero
    chk[4] = err;
    return chk;
  endfunction

  task automatic expect_equal(input string what, input logic [31:0] exp_val,
                              input logic [31:0] act_val);
    check_count++;
    assert (act_val === exp_val)
      else begin
        error_count++;
        $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, exp_val, act_val);
      end
  endtask

  // Outputs still hold the values of the cycle that ends at this edge
  always @(posedge clk_i) begin
    logic              instr_fault;
    logic              data_fault;
    logic [1:0]        instr_head;
    logic [2:0]        data_head;
    logic [RCHK_W-1:0] exp_rchk;
    logic              rchk_bad;
    if (rst) begin
      enable_q = 1'b1;
      status_q = 1'b0;
      fault_q  = 1'b0;
      instr_q.delete();
      data_q.delete();
    end else begin
      expect_equal("integrity_enable", enable_q, integrity_enable);
      expect_equal("alert_major", fault_q, alert_major);
      expect_equal("alert_status", status_q, alert_status);
      expect_equal("instr_reqpar", !instr_req, instr_reqpar);
      expect_equal("data_reqpar", !data_req, data_reqpar);
      if (instr_req) begin
        expect_equal("instr_achk", ref_achk(instr_addr, '0, '1, 1'b0, instr_prot,
                                            instr_memtype, instr_dbg), instr_achk);
      end
      if (data_req) begin
        expect_equal("data_achk", ref_achk(data_addr, data_wdata, data_be, data_we,
                                           data_prot, data_memtype, data_dbg), data_achk);
      end

      // A parity strobe equal to its signal is a fault
      instr_fault = (instr_gntpar == instr_gnt) || (instr_rvalidpar == instr_rvalid);
      data_fault  = (data_gntpar == data_gnt) || (data_rvalidpar == data_rvalid);

      if (instr_rvalid && instr_q.size() == 0) begin
        error_count++;
        $display("Instruction response in test %s with no request outstanding", test_name);
      end else if (instr_rvalid) begin
        instr_head  = instr_q.pop_front();
        exp_rchk    = ref_rchk(instr_rdata, instr_err);
        rchk_bad    = instr_head[1] && enable_q && (instr_rchk != exp_rchk);
        instr_fault = instr_fault || rchk_bad;
        expect_equal("instr_integrity_err",
                     (instr_rvalidpar == instr_rvalid) || instr_head[0] || rchk_bad,
                     instr_integrity_err);
      end

      if (data_rvalid && data_q.size() == 0) begin
        error_count++;
        $display("Data response in test %s with no request outstanding", test_name);
      end else if (data_rvalid) begin
        data_head = data_q.pop_front();
        exp_rchk  = ref_rchk(data_rdata, data_err);
        // Only bit 4 is compared on store responses
        if (data_head[0]) begin
          rchk_bad = data_rchk[4] != exp_rchk[4];
        end else begin
          rchk_bad = data_rchk != exp_rchk;
        end
        rchk_bad   = rchk_bad && data_head[2] && enable_q;
        data_fault = data_fault || rchk_bad;
        expect_equal("data_integrity_err",
                     (data_rvalidpar == data_rvalid) || data_head[1] || rchk_bad,
                     data_integrity_err);
      end

      if (instr_req && instr_gnt) begin
        instr_q.push_back({enable_q, instr_gntpar == instr_gnt});
      end
      if (data_req && data_gnt) begin
        data_q.push_back({enable_q, data_gntpar == data_gnt, data_we});
      end

      if (cfg_we) begin
        enable_q = cfg_wdata;
      end
      if (instr_fault || data_fault) begin
        status_q = 1'b1;
      end else if (status_clear) begin
        status_q = 1'b0;
      end
      fault_q = instr_fault || data_fault;
    end
  end

endmodule

`default_nettype wire

/* design/obi_integrity_top.sv */
// OBI bus interface integrity unit
// Instruction and data channel checkers sharing one control register block
`default_nettype none

module obi_integrity_top
  import obi_integrity_pkg::*;
(
  input  wire logic                 clk_i,
  input  wire logic                 rst,
  // Instruction port
  input  wire logic                 instr_req,
  input  wire logic [ADDR_W-1:0]    instr_addr,
  input  wire logic [PROT_W-1:0]    instr_prot,
  input  wire logic [MEMTYPE_W-1:0] instr_memtype,
  input  wire logic                 instr_dbg,
  input  wire logic                 instr_gnt,
  input  wire logic                 instr_gntpar,
  input  wire logic                 instr_rvalid,
  input  wire logic                 instr_rvalidpar,
  input  wire logic [DATA_W-1:0]    instr_rdata,
  input  wire logic                 instr_err,
  input  wire logic [RCHK_W-1:0]    instr_rchk,
  output logic                      instr_reqpar,
  output logic [ACHK_W-1:0]         instr_achk,
  output logic                      instr_integrity_err,
  // Data port
  input  wire logic                 data_req,
  input  wire logic [ADDR_W-1:0]    data_addr,
  input  wire logic [PROT_W-1:0]    data_prot,
  input  wire logic [MEMTYPE_W-1:0] data_memtype,
  input  wire logic                 data_dbg,
  input  wire logic                 data_we,
  input  wire logic [BE_W-1:0]      data_be,
  input  wire logic [DATA_W-1:0]    data_wdata,
  input  wire logic                 data_gnt,
  input  wire logic                 data_gntpar,
  input  wire logic                 data_rvalid,
  input  wire logic                 data_rvalidpar,
  input  wire logic [DATA_W-1:0]    data_rdata,
  input  wire logic                 data_err,
  input  wire logic [RCHK_W-1:0]    data_rchk,
  output logic                      data_reqpar,
  output logic [ACHK_W-1:0]         data_achk,
  output logic                      data_integrity_err,
  // Config and alerts
  input  wire logic                 cfg_we,
  input  wire logic                 cfg_wdata,
  input  wire logic                 status_clear,
  output logic                      integrity_enable,
  output logic                      alert_major,
  output logic                      alert_status
);

  logic instr_fault;
  logic data_fault;

  // Port names match the channel and register block ports one to one
  obi_instr_channel u_instr_channel (.*);

  obi_data_channel u_data_channel (.*);

  integrity_csr u_integrity_csr (.*);

endmodule

`default_nettype wire

/* design/integrity_csr.sv */
// Integrity control registers
// Holds the integrity enable bit, the sticky alert status and
// the one-cycle major alert raised after any channel fault
`default_nettype none

module integrity_csr (
  input  wire logic clk_i,
  input  wire logic rst,
  input  wire logic cfg_we,
  input  wire logic cfg_wdata,
  input  wire logic status_clear,
  input  wire logic instr_fault,
  input  wire logic data_fault,
  output logic      integrity_enable,
  output logic      alert_major,
  output logic      alert_status
);

  logic any_fault;

  assign any_fault = instr_fault || data_fault;

  // Checking is on out of reset
  always_ff @(posedge clk_i) begin
    if (rst) begin
      integrity_enable <= 1'b1;
    end else if (cfg_we) begin
      integrity_enable <= cfg_wdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst) begin
      alert_major  <= 1'b0;
      alert_status <= 1'b0;
    end else begin
      alert_major <= any_fault;
      // New fault has priority over a clear in the same cycle
      if (any_fault) begin
        alert_status <= 1'b1;
      end else if (status_clear) begin
        alert_status <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* design/obi_data_channel.sv */
// Data port integrity channel
// Encodes achk and reqpar for loads and stores and checks responses.
// Store responses carry no rdata, so only the err parity bit of rchk is compared
`default_nettype none

module obi_data_channel
  import obi_integrity_pkg::*;
(
  input  wire logic                 clk_i,
  input  wire logic                 rst,
  input  wire logic                 data_req,
  input  wire logic [ADDR_W-1:0]    data_addr,
  input  wire logic [PROT_W-1:0]    data_prot,
  input  wire logic [MEMTYPE_W-1:0] data_memtype,
  input  wire logic                 data_dbg,
  input  wire logic                 data_we,
  input  wire logic [BE_W-1:0]      data_be,
  input  wire logic [DATA_W-1:0]    data_wdata,
  input  wire logic                 data_gnt,
  input  wire logic                 data_gntpar,
  input  wire logic                 data_rvalid,
  input  wire logic                 data_rvalidpar,
  input  wire logic [DATA_W-1:0]    data_rdata,
  input  wire logic                 data_err,
  input  wire logic [RCHK_W-1:0]    data_rchk,
  input  wire logic                 integrity_enable,
  output logic                      data_reqpar,
  output logic [ACHK_W-1:0]         data_achk,
  output logic                      data_integrity_err,
  output logic                      data_fault
);

  data_entry_t       push_entry;
  data_entry_t       head_entry;
  logic              fifo_empty;
  logic              gnt_par_err;
  logic              rvalid_par_err;
  logic [RCHK_W-1:0] rchk_exp;
  logic              rchk_mismatch;
  logic              rchk_err;

  assign data_reqpar = ~data_req;
  assign data_achk   = calc_achk(data_addr, data_wdata, data_be, data_we,
                                 data_prot, data_memtype, data_dbg);

  assign gnt_par_err    = (data_gntpar == data_gnt);
  assign rvalid_par_err = (data_rvalidpar == data_rvalid);

  assign push_entry = '{
    had_integrity: integrity_enable,
    gnt_fault:     gnt_par_err,
    is_store:      data_we
  };

  obi_outstanding_fifo #(
    .DEPTH   (OUTSTANDING_DEPTH),
    .entry_t (data_entry_t)
  ) u_fifo (
    .clk_i      (clk_i),
    .rst        (rst),
    .push       (data_req && data_gnt),
    .push_entry (push_entry),
    .pop        (data_rvalid),
    .head_entry (head_entry),
    .empty      (fifo_empty)
  );

  assign rchk_exp = calc_rchk(data_rdata, data_err);

  always_comb begin
    if (head_entry.is_store) begin
      rchk_mismatch = (data_rchk[RCHK_STORE_BIT] != rchk_exp[RCHK_STORE_BIT]);
    end else begin
      rchk_mismatch = (data_rchk != rchk_exp);
    end
  end

  // Checked only for requests granted while integrity was on
  assign rchk_err = data_rvalid && !fifo_empty && head_entry.had_integrity &&
                    integrity_enable && rchk_mismatch;

  assign data_integrity_err = data_rvalid &&
                              (rvalid_par_err || head_entry.gnt_fault || rchk_err);
  assign data_fault         = gnt_par_err || rvalid_par_err || rchk_err;

endmodule

`default_nettype wire

/* design/obi_instr_channel.sv */
// Instruction port integrity channel
// Encodes achk and reqpar for fetches and checks parity and rchk on responses
`default_nettype none

module obi_instr_channel
  import obi_integrity_pkg::*;
(
  input  wire logic                 clk_i,
  input  wire logic                 rst,
  input  wire logic                 instr_req,
  input  wire logic [ADDR_W-1:0]    instr_addr,
  input  wire logic [PROT_W-1:0]    instr_prot,
  input  wire logic [MEMTYPE_W-1:0] instr_memtype,
  input  wire logic                 instr_dbg,
  input  wire logic                 instr_gnt,
  input  wire logic                 instr_gntpar,
  input  wire logic                 instr_rvalid,
  input  wire logic                 instr_rvalidpar,
  input  wire logic [DATA_W-1:0]    instr_rdata,
  input  wire logic                 instr_err,
  input  wire logic [RCHK_W-1:0]    instr_rchk,
  input  wire logic                 integrity_enable,
  output logic                      instr_reqpar,
  output logic [ACHK_W-1:0]         instr_achk,
  output logic                      instr_integrity_err,
  output logic                      instr_fault
);

  instr_entry_t      push_entry;
  instr_entry_t      head_entry;
  logic              fifo_empty;
  logic              gnt_par_err;
  logic              rvalid_par_err;
  logic [RCHK_W-1:0] rchk_exp;
  logic              rchk_err;

  assign instr_reqpar = ~instr_req;
  assign instr_achk   = calc_achk(instr_addr, INSTR_WDATA, INSTR_BE, INSTR_WE,
                                  instr_prot, instr_memtype, instr_dbg);

  // Parity strobes must always be the inverse of their signal
  assign gnt_par_err    = (instr_gntpar == instr_gnt);
  assign rvalid_par_err = (instr_rvalidpar == instr_rvalid);

  assign push_entry = '{had_integrity: integrity_enable, gnt_fault: gnt_par_err};

  obi_outstanding_fifo #(
    .DEPTH   (OUTSTANDING_DEPTH),
    .entry_t (instr_entry_t)
  ) u_fifo (
    .clk_i      (clk_i),
    .rst        (rst),
    .push       (instr_req && instr_gnt),
    .push_entry (push_entry),
    .pop        (instr_rvalid),
    .head_entry (head_entry),
    .empty      (fifo_empty)
  );

  assign rchk_exp = calc_rchk(instr_rdata, instr_err);
  assign rchk_err = instr_rvalid && !fifo_empty && head_entry.had_integrity &&
                    integrity_enable && (instr_rchk != rchk_exp);

  assign instr_integrity_err = instr_rvalid &&
                               (rvalid_par_err || head_entry.gnt_fault || rchk_err);
  assign instr_fault         = gnt_par_err || rvalid_par_err || rchk_err;

endmodule

`default_nettype wire

/* design/obi_outstanding_fifo.sv */
// Outstanding request FIFO
// Keeps per-request attributes from grant until the in-order response
`default_nettype none

module obi_outstanding_fifo #(
  parameter int  DEPTH   = 2,
  parameter type entry_t = logic
) (
  input  wire logic   clk_i,
  input  wire logic   rst,
  input  wire logic   push,
  input  wire entry_t push_entry,
  input  wire logic   pop,
  output entry_t      head_entry,
  output logic        empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  entry_t           mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign empty   = (count == '0);
  assign full    = (count == CNT_W'(DEPTH));
  assign do_pop  = pop && !empty;
  // A pop in the same cycle frees a slot for the new entry
  assign do_push = push && (!full || do_pop);

  assign head_entry = mem[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= push_entry;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/obi_integrity_pkg.sv */
// OBI interface integrity package
// Shared widths, outstanding-request entry types and the achk/rchk
// checksum rules used by both bus channels
`default_nettype none

package obi_integrity_pkg;

  localparam int ADDR_W            = 32;
  localparam int DATA_W            = 32;
  localparam int BE_W              = DATA_W / 8;
  localparam int PROT_W            = 3;
  localparam int MEMTYPE_W         = 2;
  localparam int ACHK_W            = 13;
  localparam int RCHK_W            = 5;
  localparam int RCHK_STORE_BIT    = 4;
  localparam int OUTSTANDING_DEPTH = 2;

  // Fixed values of the fields not carried on the bus
  localparam logic [5:0] ATOP_ASSUMED   = 6'b00_0000;
  localparam logic [7:0] MID_ASSUMED    = 8'h00;
  localparam logic       EXOKAY_ASSUMED = 1'b0;

  // Instruction fetches are always full-word reads
  localparam logic [DATA_W-1:0] INSTR_WDATA = '0;
  localparam logic [BE_W-1:0]   INSTR_BE    = '1;
  localparam logic              INSTR_WE    = 1'b0;

  typedef struct packed {
    logic had_integrity;
    logic gnt_fault;
  } instr_entry_t;

  typedef struct packed {
    logic had_integrity;
    logic gnt_fault;
    logic is_store;
  } data_entry_t;

  // Address-phase checksum with wdata bytes in the top bits and address bytes at the bottom
  function automatic logic [ACHK_W-1:0] calc_achk(
    input logic [ADDR_W-1:0]    addr,
    input logic [DATA_W-1:0]    wdata,
    input logic [BE_W-1:0]      be,
    input logic                 we,
    input logic [PROT_W-1:0]    prot,
    input logic [MEMTYPE_W-1:0] memtype,
    input logic                 dbg
  );
    return {^wdata[31:24], ^wdata[23:16], ^wdata[15:8], ^wdata[7:0],
            ~^dbg, ^ATOP_ASSUMED, ^MID_ASSUMED,
            ~^{be, we}, ~^{prot, memtype},
            ^addr[31:24], ^addr[23:16], ^addr[15:8], ^addr[7:0]};
  endfunction

  // Response checksum with the err and exokay parity in bit 4
  function automatic logic [RCHK_W-1:0] calc_rchk(
    input logic [DATA_W-1:0] rdata,
    input logic              err
  );
    return {^{err, EXOKAY_ASSUMED},
            ^rdata[31:24], ^rdata[23:16], ^rdata[15:8], ^rdata[7:0]};
  endfunction

endpackage

`default_nettype wire
